//--- rtl/exmem2_pkg.sv
/*
 * Shared definitions for the EXMEM2 execute and I/O unit
 * - Data word, register index and memory offset types
 * - Issue opcode and multi-cycle ALU opcode enums
 * - State enums for the ALU, the memory-unit requester and the control
 * - Divide-by-zero quotient constant
 */
package exmem2_pkg;

    // ========================================================================
    // Widths and basic types
    // ========================================================================

    localparam int WORD_BITS = 32;

    typedef logic [WORD_BITS-1:0] word_t;

    // Register 0 is never written back
    typedef logic [3:0] reg_addr_t;

    typedef logic signed [15:0] offset_t;

    // ========================================================================
    // Opcodes
    // ========================================================================

    typedef enum logic [2:0] {
        op_mult     = 3'd0,  // Low word of product
        op_mulhiu   = 3'd1,  // High word of unsigned product
        op_divs     = 3'd2,
        op_divu     = 3'd3,
        op_mods     = 3'd4,
        op_modu     = 3'd5,
        op_io_read  = 3'd6,
        op_io_write = 3'd7
    } exec_op_e;

    // Arithmetic subset handled by the multi-cycle ALU
    typedef enum logic [2:0] {
        malu_mult   = 3'd0,
        malu_mulhiu = 3'd1,
        malu_divs   = 3'd2,
        malu_divu   = 3'd3,
        malu_mods   = 3'd4,
        malu_modu   = 3'd5
    } malu_op_e;

    // ========================================================================
    // State machines
    // ========================================================================

    typedef enum logic [1:0] {
        malu_st_idle = 2'd0,
        malu_st_run  = 2'd1,
        malu_st_done = 2'd2
    } malu_state_e;

    typedef enum logic [1:0] {
        mu_st_idle      = 2'd0,
        mu_st_started   = 2'd1,
        mu_st_wait_done = 2'd2
    } mu_state_e;

    typedef enum logic [1:0] {
        ctrl_idle      = 2'd0,
        ctrl_wait_malu = 2'd1,
        ctrl_wait_mu   = 2'd2,
        ctrl_retire    = 2'd3
    } ctrl_state_e;

    // Quotient of any divide by zero
    localparam word_t DIV_ZERO_QUOTIENT = '1;

endpackage

//--- rtl/multicycle_alu.sv
/*
 * Iterative multiply/divide unit
 * - Shift-add multiplier, low word or unsigned high word
 * - Restoring divider, signed and unsigned quotient and remainder
 * - Start/done handshake, done comes DATA_WIDTH+1 cycles after start
 */
`timescale 1ns/1ps

module multicycle_alu
    import exmem2_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     start,
    input  word_t    a,
    input  word_t    b,
    input  malu_op_e op,

    output logic     done,
    output word_t    y
);

    localparam int CNT_BITS = $clog2(DATA_WIDTH);
    localparam logic [CNT_BITS-1:0] LAST_STEP = CNT_BITS'(DATA_WIDTH - 1);

    malu_state_e         state;
    logic [CNT_BITS-1:0] step;

    // Operation registered at start
    malu_op_e              op_r;
    logic                  neg_q;
    logic                  neg_r;
    logic                  div_zero;
    logic [DATA_WIDTH-1:0] opnd_r;

    // hi:lo is the product, or remainder:quotient while dividing
    logic [DATA_WIDTH-1:0] hi;
    logic [DATA_WIDTH-1:0] lo;

    logic [DATA_WIDTH-1:0] a_in;
    logic [DATA_WIDTH-1:0] b_in;
    logic                  signed_op;
    logic                  a_neg;
    logic                  b_neg;
    logic                  mul_r;
    logic                  quot_r;

    logic [DATA_WIDTH:0]   add_sum;
    logic [DATA_WIDTH:0]   trial;
    logic [DATA_WIDTH:0]   diff;
    logic [DATA_WIDTH-1:0] result;

    assign a_in      = a[DATA_WIDTH-1:0];
    assign b_in      = b[DATA_WIDTH-1:0];
    assign signed_op = (op == malu_divs) || (op == malu_mods);
    assign a_neg     = signed_op && a_in[DATA_WIDTH-1];
    assign b_neg     = signed_op && b_in[DATA_WIDTH-1];

    assign mul_r  = (op_r == malu_mult) || (op_r == malu_mulhiu);
    assign quot_r = (op_r == malu_divs) || (op_r == malu_divu);

    // One multiply step adds the multiplicand when the multiplier LSB is set
    assign add_sum = {1'b0, hi} + (lo[0] ? {1'b0, opnd_r} : '0);

    // One divide step tries to subtract the divisor from the shifted remainder
    assign trial = {hi, lo[DATA_WIDTH-1]};
    assign diff  = trial - {1'b0, opnd_r};

    // Sign fix of the final result, division truncates toward zero
    always_comb begin
        case (op_r)
            malu_mult:            result = lo;
            malu_mulhiu:          result = hi;
            malu_divs, malu_divu: result = neg_q ? -lo : lo;
            default:              result = neg_r ? -hi : hi;
        endcase
    end

    // ========================================================================
    // Sequencing
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= malu_st_idle;
            step  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                malu_st_idle: begin
                    step <= '0;
                    if (start) begin
                        state <= malu_st_run;
                    end
                end

                malu_st_run: begin
                    step <= step + CNT_BITS'(1);
                    if (step == LAST_STEP) begin
                        state <= malu_st_done;
                    end
                end

                malu_st_done: begin
                    done  <= 1'b1;
                    state <= malu_st_idle;
                end

                default: state <= malu_st_idle;
            endcase
        end
    end

    // ========================================================================
    // Datapath
    // ========================================================================

    always_ff @(posedge clk) begin
        case (state)
            malu_st_idle: begin
                if (start) begin
                    op_r     <= op;
                    opnd_r   <= b_neg ? -b_in : b_in;
                    hi       <= '0;
                    lo       <= a_neg ? -a_in : a_in;
                    neg_q    <= a_neg ^ b_neg;
                    neg_r    <= a_neg;
                    div_zero <= (b_in == '0);
                end
            end

            malu_st_run: begin
                if (mul_r) begin
                    hi <= add_sum[DATA_WIDTH:1];
                    lo <= {add_sum[0], lo[DATA_WIDTH-1:1]};
                end else if (!diff[DATA_WIDTH]) begin
                    hi <= diff[DATA_WIDTH-1:0];
                    lo <= {lo[DATA_WIDTH-2:0], 1'b1};
                end else begin
                    hi <= trial[DATA_WIDTH-1:0];
                    lo <= {lo[DATA_WIDTH-2:0], 1'b0};
                end
            end

            malu_st_done: begin
                // Remainder of a divide by zero already comes out as a
                if (quot_r && div_zero) begin
                    y <= DIV_ZERO_QUOTIENT;
                end else begin
                    y <= word_t'(result);
                end
            end

            default: ;
        endcase
    end

endmodule

//--- rtl/mu_requester.sv
/*
 * Memory-unit requester
 * - Turns a one-cycle request into a memory-unit start pulse
 * - Waits for the memory-unit done and captures its read data
 * - Pulses finished with the captured result
 */
`timescale 1ns/1ps

module mu_requester
    import exmem2_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // Request from the control
    input  logic  req,
    input  word_t req_addr,
    input  word_t req_data,
    input  logic  req_we,

    // External memory unit
    output logic  mu_start,
    output word_t mu_addr,
    output word_t mu_data,
    output logic  mu_we,
    input  logic  mu_done,
    input  word_t mu_q,

    // Completion back to the control
    output logic  finished,
    output word_t result
);

    mu_state_e state;

    // ========================================================================
    // Request state machine
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= mu_st_idle;
            mu_start <= 1'b0;
            mu_addr  <= '0;
            mu_data  <= '0;
            mu_we    <= 1'b0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            case (state)
                mu_st_idle: begin
                    if (req) begin
                        mu_start <= 1'b1;
                        mu_addr  <= req_addr;
                        mu_data  <= req_data;
                        mu_we    <= req_we;
                        state    <= mu_st_started;
                    end
                end

                // Request lines are only valid during the start cycle
                mu_st_started: begin
                    mu_start <= 1'b0;
                    mu_addr  <= '0;
                    mu_data  <= '0;
                    mu_we    <= 1'b0;
                    state    <= mu_st_wait_done;
                end

                mu_st_wait_done: begin
                    if (mu_done) begin
                        finished <= 1'b1;
                        state    <= mu_st_idle;
                    end
                end

                default: state <= mu_st_idle;
            endcase
        end
    end

    // Read data is sampled together with done
    always_ff @(posedge clk) begin
        if (state == mu_st_wait_done && mu_done) begin
            result <= mu_q;
        end
    end

endmodule

//--- rtl/exmem2_control.sv
/*
 * EXMEM2 issue and retire control
 * - Accepts one operation at a time and holds busy while it runs
 * - Computes the I/O address from operand a and the signed offset
 * - Dispatches to the multi-cycle ALU or the memory-unit requester
 * - Selects the finished result and drives the writeback pulse
 */
`timescale 1ns/1ps

module exmem2_control
    import exmem2_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // Issue side
    input  logic      issue_valid,
    input  exec_op_e  issue_op,
    input  word_t     issue_a,
    input  word_t     issue_b,
    input  offset_t   issue_offset,
    input  reg_addr_t issue_dreg,
    output logic      busy,

    // Multi-cycle ALU
    output logic      malu_start,
    output word_t     malu_a,
    output word_t     malu_b,
    output malu_op_e  malu_op,
    input  logic      malu_done,
    input  word_t     malu_y,

    // Memory-unit requester
    output logic      mu_req,
    output word_t     mu_req_addr,
    output word_t     mu_req_data,
    output logic      mu_req_we,
    input  logic      mu_finished,
    input  word_t     mu_result,

    // Writeback
    output logic      wb_valid,
    output logic      wb_we,
    output reg_addr_t wb_dreg,
    output word_t     wb_data
);

    ctrl_state_e state;
    exec_op_e    op_r;
    reg_addr_t   dreg_r;
    word_t       result_r;

    logic        accept;
    logic        issue_io;
    word_t       issue_addr;
    malu_op_e    issue_malu_op;

    assign busy       = (state != ctrl_idle);
    assign accept     = issue_valid && !busy;
    assign issue_io   = (issue_op == op_io_read) || (issue_op == op_io_write);
    assign issue_addr = issue_a + {{(WORD_BITS - $bits(offset_t)){issue_offset[15]}}, issue_offset};

    always_comb begin
        case (issue_op)
            op_mulhiu: issue_malu_op = malu_mulhiu;
            op_divs:   issue_malu_op = malu_divs;
            op_divu:   issue_malu_op = malu_divu;
            op_mods:   issue_malu_op = malu_mods;
            op_modu:   issue_malu_op = malu_modu;
            default:   issue_malu_op = malu_mult;
        endcase
    end

    // ========================================================================
    // Issue, wait and retire
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ctrl_idle;
            malu_start <= 1'b0;
            mu_req     <= 1'b0;
        end else begin
            malu_start <= 1'b0;
            mu_req     <= 1'b0;
            case (state)
                ctrl_idle: begin
                    if (accept && issue_io) begin
                        mu_req <= 1'b1;
                        state  <= ctrl_wait_mu;
                    end else if (accept) begin
                        malu_start <= 1'b1;
                        state      <= ctrl_wait_malu;
                    end
                end

                ctrl_wait_malu: if (malu_done) state <= ctrl_retire;

                ctrl_wait_mu: if (mu_finished) state <= ctrl_retire;

                ctrl_retire: state <= ctrl_idle;

                default: state <= ctrl_idle;
            endcase
        end
    end

    // Operands for both units are captured on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            op_r        <= issue_op;
            dreg_r      <= issue_dreg;
            malu_a      <= issue_a;
            malu_b      <= issue_b;
            malu_op     <= issue_malu_op;
            mu_req_addr <= issue_addr;
            mu_req_data <= issue_b;
            mu_req_we   <= (issue_op == op_io_write);
        end
        if (state == ctrl_wait_malu && malu_done) begin
            result_r <= malu_y;
        end
        if (state == ctrl_wait_mu && mu_finished) begin
            result_r <= (op_r == op_io_write) ? '0 : mu_result;
        end
    end

    // Writeback has no back-pressure
    assign wb_valid = (state == ctrl_retire);
    assign wb_we    = wb_valid && (op_r != op_io_write) && (dreg_r != '0);
    assign wb_dreg  = dreg_r;
    assign wb_data  = result_r;

endmodule

//--- rtl/exmem2_top.sv
/*
 * EXMEM2 execute and I/O unit, top level
 * - Control with issue and writeback ports
 * - Multi-cycle ALU and memory-unit requester
 */
`timescale 1ns/1ps

module exmem2_top
    import exmem2_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // Issue side
    input  logic      issue_valid,
    input  exec_op_e  issue_op,
    input  word_t     issue_a,
    input  word_t     issue_b,
    input  offset_t   issue_offset,
    input  reg_addr_t issue_dreg,
    output logic      busy,

    // Writeback
    output logic      wb_valid,
    output logic      wb_we,
    output reg_addr_t wb_dreg,
    output word_t     wb_data,

    // Memory unit
    output logic      mu_start,
    output word_t     mu_addr,
    output word_t     mu_data,
    output logic      mu_we,
    input  logic      mu_done,
    input  word_t     mu_q
);

    logic     malu_start;
    word_t    malu_a;
    word_t    malu_b;
    malu_op_e malu_op;
    logic     malu_done;
    word_t    malu_y;

    logic     mu_req;
    word_t    mu_req_addr;
    word_t    mu_req_data;
    logic     mu_req_we;
    logic     mu_finished;
    word_t    mu_result;

    exmem2_control i_control (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_offset (issue_offset),
        .issue_dreg   (issue_dreg),
        .busy         (busy),
        .malu_start   (malu_start),
        .malu_a       (malu_a),
        .malu_b       (malu_b),
        .malu_op      (malu_op),
        .malu_done    (malu_done),
        .malu_y       (malu_y),
        .mu_req       (mu_req),
        .mu_req_addr  (mu_req_addr),
        .mu_req_data  (mu_req_data),
        .mu_req_we    (mu_req_we),
        .mu_finished  (mu_finished),
        .mu_result    (mu_result),
        .wb_valid     (wb_valid),
        .wb_we        (wb_we),
        .wb_dreg      (wb_dreg),
        .wb_data      (wb_data)
    );

    multicycle_alu #(
        .DATA_WIDTH (WORD_BITS)
    ) i_malu (
        .clk   (clk),
        .reset (reset),
        .start (malu_start),
        .a     (malu_a),
        .b     (malu_b),
        .op    (malu_op),
        .done  (malu_done),
        .y     (malu_y)
    );

    mu_requester i_mu (
        .clk      (clk),
        .reset    (reset),
        .req      (mu_req),
        .req_addr (mu_req_addr),
        .req_data (mu_req_data),
        .req_we   (mu_req_we),
        .mu_start (mu_start),
        .mu_addr  (mu_addr),
        .mu_data  (mu_data),
        .mu_we    (mu_we),
        .mu_done  (mu_done),
        .mu_q     (mu_q),
        .finished (mu_finished),
        .result   (mu_result)
    );

endmodule

//--- bench/tb_mu_model.sv
/*
 * Behavioral memory unit for the EXMEM2 testbench
 * - 64-word memory indexed by the low address bits
 * - Unwritten words read as the inverted full address
 * - Answers each start with done after 1 to 8 cycles
 */
`timescale 1ns/1ps

module tb_mu_model
    import exmem2_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  mu_start,
    input  word_t mu_addr,
    input  word_t mu_data,
    input  logic  mu_we,
    output logic  mu_done,
    output word_t mu_q
);

    integer seed = 23032;
    word_t  mem     [64];
    logic   written [64];
    word_t  req_addr;
    int     delay;

    initial begin
        mu_done = 1'b0;
        mu_q    = '0;
        delay   = 0;
        for (int i = 0; i < 64; i++) begin
            written[i] = 1'b0;
        end
    end

    // Outputs change on the falling edge, the requester samples on the rising edge
    always @(negedge clk) begin
        mu_done = 1'b0;
        if (reset) begin
            delay = 0;
        end else if (mu_start) begin
            req_addr = mu_addr;
            if (mu_we) begin
                mem[mu_addr[5:0]]     = mu_data;
                written[mu_addr[5:0]] = 1'b1;
            end
            delay = 1 + ($unsigned($random(seed)) % 8);
        end else if (delay > 0) begin
            delay = delay - 1;
            if (delay == 0) begin
                mu_done = 1'b1;
                mu_q    = written[req_addr[5:0]] ? mem[req_addr[5:0]] : ~req_addr;
            end
        end
    end

endmodule

//--- bench/tb_exmem2.sv
/*
 * Testbench for the EXMEM2 execute and I/O unit
 * - Clock, reset and a behavioral memory unit
 * - Stimulus table with hand-computed expected writeback values
 * - Compare tasks, retirement count and cycle-limit timeout
 */
`timescale 1ns/1ps

module tb_exmem2
    import exmem2_pkg::*;
();

    typedef struct packed {
        exec_op_e  op;
        word_t     a;
        word_t     b;
        offset_t   offset;
        reg_addr_t dreg;
        word_t     exp_data;
        logic      exp_we;
    } entry_t;

    logic      clk;
    logic      reset;
    logic      issue_valid;
    exec_op_e  issue_op;
    word_t     issue_a;
    word_t     issue_b;
    offset_t   issue_offset;
    reg_addr_t issue_dreg;
    logic      busy;
    logic      wb_valid;
    logic      wb_we;
    reg_addr_t wb_dreg;
    word_t     wb_data;
    logic      mu_start;
    word_t     mu_addr;
    word_t     mu_data;
    logic      mu_we;
    logic      mu_done;
    word_t     mu_q;

    entry_t stim [$];
    int     cycle_count  = 0;
    int     cycle_limit  = 20;
    int     retire_count = 0;

    exmem2_top i_dut (.*);

    tb_mu_model i_mu_model (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================================================
    // Failure reporting and compare tasks
    // ========================================================================

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic void add_entry(input exec_op_e op, input word_t a, input word_t b,
                                      input offset_t offset, input reg_addr_t dreg,
                                      input word_t exp_data, input logic exp_we);
        entry_t e;
        e.op       = op;
        e.a        = a;
        e.b        = b;
        e.offset   = offset;
        e.dreg     = dreg;
        e.exp_data = exp_data;
        e.exp_we   = exp_we;
        stim.push_back(e);
    endfunction

    // Every rising edge counts toward the limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            retire_count = retire_count + 1;
        end
    end

    // Memory-unit request lines are zero outside the start cycle
    always @(negedge clk) begin
        if (!reset && !mu_start) begin
            check_word("mu_addr", mu_addr, '0);
            check_word("mu_data", mu_data, '0);
            check_flag("mu_we", mu_we, 1'b0);
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    initial begin
        reset        = 1'b1;
        issue_valid  = 1'b0;
        issue_op     = op_mult;
        issue_a      = '0;
        issue_b      = '0;
        issue_offset = '0;
        issue_dreg   = '0;

        // Multiply, low and high words
        add_entry(op_mult,     32'h7,        32'h6,        16'sd0,  4'd1,  32'h2A,       1'b1);
        add_entry(op_mult,     32'hFFFFFFFD, 32'h5,        16'sd0,  4'd2,  32'hFFFFFFF1, 1'b1);
        add_entry(op_mulhiu,   32'hFFFFFFFF, 32'hFFFFFFFF, 16'sd0,  4'd3,  32'hFFFFFFFE, 1'b1);
        add_entry(op_mulhiu,   32'h12345678, 32'h10,       16'sd0,  4'd4,  32'h1,        1'b1);
        add_entry(op_mult,     32'hFFFFFFFF, 32'hFFFFFFF9, 16'sd0,  4'd5,  32'h7,        1'b1);
        // Divide and remainder with mixed signs
        add_entry(op_divs,     32'hFFFFFFF9, 32'h2,        16'sd0,  4'd6,  32'hFFFFFFFD, 1'b1);
        add_entry(op_mods,     32'hFFFFFFF9, 32'h2,        16'sd0,  4'd7,  32'hFFFFFFFF, 1'b1);
        add_entry(op_divs,     32'h7,        32'hFFFFFFFE, 16'sd0,  4'd8,  32'hFFFFFFFD, 1'b1);
        add_entry(op_mods,     32'h7,        32'hFFFFFFFE, 16'sd0,  4'd9,  32'h1,        1'b1);
        add_entry(op_divu,     32'hFFFFFFF9, 32'h2,        16'sd0,  4'd10, 32'h7FFFFFFC, 1'b1);
        add_entry(op_modu,     32'hFFFFFFF9, 32'h2,        16'sd0,  4'd11, 32'h1,        1'b1);
        add_entry(op_divs,     32'hFFFFFF9C, 32'hFFFFFFF9, 16'sd0,  4'd12, 32'hE,        1'b1);
        add_entry(op_mods,     32'hFFFFFF9C, 32'hFFFFFFF9, 16'sd0,  4'd13, 32'hFFFFFFFE, 1'b1);
        // Divide by zero
        add_entry(op_divu,     32'h4D2,      32'h0,        16'sd0,  4'd14, 32'hFFFFFFFF, 1'b1);
        add_entry(op_modu,     32'h4D2,      32'h0,        16'sd0,  4'd15, 32'h4D2,      1'b1);
        add_entry(op_mods,     32'hFFFFFFFB, 32'h0,        16'sd0,  4'd1,  32'hFFFFFFFB, 1'b1);
        add_entry(op_divs,     32'hFFFFFFFB, 32'h0,        16'sd0,  4'd2,  32'hFFFFFFFF, 1'b1);
        // I/O write then read back, negative offsets, unwritten words
        add_entry(op_io_write, 32'h100,      32'hCAFEF00D, 16'sd16, 4'd3,  32'h0,        1'b0);
        add_entry(op_io_read,  32'h100,      32'h0,        16'sd16, 4'd4,  32'hCAFEF00D, 1'b1);
        add_entry(op_io_write, 32'h200,      32'h5A5A1234, -16'sd8, 4'd5,  32'h0,        1'b0);
        add_entry(op_io_read,  32'h1F0,      32'h0,        16'sd8,  4'd6,  32'h5A5A1234, 1'b1);
        add_entry(op_io_read,  32'h300,      32'h0,        -16'sd4, 4'd7,  32'hFFFFFD03, 1'b1);
        // Destination register 0 is never written
        add_entry(op_io_read,  32'h40,       32'h0,        16'sd0,  4'd0,  32'hFFFFFFBF, 1'b0);
        add_entry(op_mult,     32'h3,        32'h3,        16'sd0,  4'd0,  32'h9,        1'b0);
        add_entry(op_divu,     32'h64,       32'h7,        16'sd0,  4'd8,  32'hE,        1'b1);

        cycle_limit = 60 * stim.size() + 20;

        repeat (3) @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("wb_we", wb_we, 1'b0);
        check_flag("mu_start", mu_start, 1'b0);
        reset = 1'b0;

        foreach (stim[i]) begin
            while (busy) @(negedge clk);
            issue_op     = stim[i].op;
            issue_a      = stim[i].a;
            issue_b      = stim[i].b;
            issue_offset = stim[i].offset;
            issue_dreg   = stim[i].dreg;
            issue_valid  = 1'b1;
            // Still high for one busy cycle and not taken again
            @(negedge clk);
            @(negedge clk);
            issue_valid = 1'b0;
            do @(negedge clk); while (!wb_valid);
            check_word("wb_data", wb_data, stim[i].exp_data);
            check_flag("wb_we", wb_we, stim[i].exp_we);
            check_reg("wb_dreg", wb_dreg, stim[i].dreg);
        end

        repeat (4) @(negedge clk);
        if (retire_count != stim.size()) begin
            $display("MISMATCH retire_count: got 0x%0h expected 0x%0h",
                     retire_count, stim.size());
            stop_with_failure();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- project.f
rtl/exmem2_pkg.sv
rtl/multicycle_alu.sv
rtl/mu_requester.sv
rtl/exmem2_control.sv
rtl/exmem2_top.sv
bench/tb_mu_model.sv
bench/tb_exmem2.sv

//--- Bender.yml
package:
  name: exmem2

sources:
  - rtl/exmem2_pkg.sv
  - rtl/multicycle_alu.sv
  - rtl/mu_requester.sv
  - rtl/exmem2_control.sv
  - rtl/exmem2_top.sv
  - target: simulation
    files:
      - bench/tb_mu_model.sv
      - bench/tb_exmem2.sv
